// File: verilog.f
design/cache_pkg.sv
design/cache_tag_array.sv
design/cache_data_array.sv
design/cache_lookup.sv
design/cache_victim_buffer.sv
design/cache_refill_engine.sv
design/cache_top.sv
tb/cache_bridge_model.sv
tb/cache_tb.sv

// File: tb/cache_tb.sv
`timescale 1ns/100ps

module cache_tb import cache_pkg::*; ();

localparam int n_req        = 400;
localparam int sweep_tries  = 16;
localparam int max_wait     = 400;
localparam int watch_cycles = (16 + n_req + 4 * sweep_tries * 2) * 40;
localparam int n_tests      = 5;
localparam int t_reset      = 0;
localparam int t_traffic    = 1;
localparam int t_wb         = 2;
localparam int t_sweep      = 3;
localparam int t_hs         = 4;

logic           clk;
logic           resetn;
logic           valid;
cpu_req_s       req;
logic           addr_ok;
logic           data_ok;
logic [31:0]    rdata;
logic           rd_req;
logic [2:0]     rd_type;
logic [31:0]    rd_addr;
logic           rd_rdy;
logic           ret_valid;
logic           ret_last;
logic [31:0]    ret_data;
logic           wr_req;
logic [2:0]     wr_type;
logic [31:0]    wr_addr;
logic [3:0]     wr_wstrb;
logic [127:0]   wr_data;
logic           wr_rdy;

logic [31:0] ref_mem [0:16383];
logic [19:0] tag_pool [3] = '{20'h00003, 20'h0000a, 20'h0000c};
logic [19:0] sweep_tag [2] = '{20'h00005, 20'h0000e};     // never stored to
logic [7:0]  idx_pool [4] = '{8'h00, 8'h01, 8'h7e, 8'hff};
string       test_name [n_tests] = '{"reset_values", "random_traffic", "writeback_data",
                                     "final_sweep", "data_ok_handshake"};
int          err_cnt [n_tests];
int          chk_cnt [n_tests];
int          pending;
int          accepted;
int          acked;
bit          abort;

cache_top dut (
        .clk(clk), .resetn(resetn), .valid(valid), .req(req),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd_type(rd_type), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_type(wr_type), .wr_addr(wr_addr), .wr_wstrb(wr_wstrb),
        .wr_data(wr_data), .wr_rdy(wr_rdy)
);

cache_bridge_model bridge (
        .clk(clk), .resetn(resetn), .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy)
);

function automatic logic [31:0] mem_init_word(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'h5ac30f0f;
endfunction

task automatic check_equal(input int id, input logic [31:0] exp, input logic [31:0] act);
        chk_cnt[id]++;
        assert (act === exp) else begin
                $display("error %s: expected %h, actual %h", test_name[id], exp, act);
                err_cnt[id]++;
        end
endtask

task automatic check_true(input int id, input bit cond, input string what);
        chk_cnt[id]++;
        assert (cond) else begin
                $display("%s: %s", test_name[id], what);
                err_cnt[id]++;
        end
endtask

task automatic end_test(input int id);
        $display("test %-18s %0d checks, %0d errors", test_name[id], chk_cnt[id], err_cnt[id]);
endtask

// one request at a time, lat counts edges from accept to data_ok
task automatic run_request(input int id, input logic op, input logic [31:0] addr,
                           input logic [3:0] strb, input logic [31:0] wdata,
                           input bit expect_hit, output int lat);
        logic [31:0] exp;
        int          n;
        lat = 0;
        @(posedge clk);
        #2;
        valid     = 1'b1;
        req.op    = op;
        req.addr  = addr;
        req.wstrb = strb;
        req.wdata = wdata;
        n = 0;
        do begin
                @(posedge clk);
                n++;
        end while (!addr_ok && n < max_wait);
        if (!addr_ok) begin
                check_true(t_hs, 1'b0, "request was never accepted");
                abort = 1'b1;
                return;
        end
        exp = ref_mem[addr[15:2]];
        if (op) begin
                for (int b = 0; b < 4; b++)
                        if (strb[b])
                                ref_mem[addr[15:2]][8*b +: 8] = wdata[8*b +: 8];
        end
        #2;
        valid = 1'b0;
        req   = '0;
        do begin
                @(posedge clk);
                lat++;
        end while (!data_ok && lat < max_wait);
        if (!data_ok) begin
                check_true(t_hs, 1'b0, "accepted request never got data_ok");
                abort = 1'b1;
                return;
        end
        if (!op)
                check_equal(id, exp, rdata);
        if (expect_hit || op)
                check_equal(t_hs, 32'd1, lat);
endtask

initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
end

// bus side checks run all the time
always @(posedge clk) begin
        if (resetn) begin
                if (data_ok) begin
                        check_true(t_hs, pending > 0, "data_ok with no request outstanding");
                        pending--;
                        acked++;
                end
                if (valid && addr_ok) begin
                        pending++;
                        accepted++;
                end
                if (rd_req && rd_rdy)
                        check_true(t_traffic, rd_addr[3:0] == 0 && rd_type == rd_type_line,
                                   "line read request has a bad address or type");
                if (wr_req && wr_rdy) begin
                        check_true(t_wb, wr_addr[3:0] == 0 && wr_type == wr_type_line &&
                                   wr_wstrb == 4'hf,
                                   "write-back has a bad address, type or strobe");
                        for (int i = 0; i < 4; i++)
                                check_equal(t_wb, ref_mem[{wr_addr[15:4], 2'b00} + i],
                                            wr_data[32*i +: 32]);
                end
        end
end

initial begin
        #(watch_cycles * 20);
        $display("timeout: run still going after %0d cycles", watch_cycles);
        $display("Simulation failed");
        $finish;
end

initial begin
        int          rnd;
        int          lat;
        int          lat2;
        int          total_err;
        int          total_chk;
        logic [19:0] tag;
        logic [19:0] prev_tag;
        logic [7:0]  idx;
        logic [7:0]  prev_idx;
        logic [1:0]  word;
        logic [31:0] baddr;
        bit          same;
        bit          settled;
        rnd = $urandom(32'hbcb4056c);
        for (int a = 0; a < 16384; a++)
                ref_mem[a] = mem_init_word(a);
        resetn = 1'b0;
        valid  = 1'b0;
        req    = '0;
        repeat (16) @(posedge clk);
        #2 resetn = 1'b1;
        @(posedge clk);
        check_true(t_reset, addr_ok === 1'b1, "addr_ok is not high after reset");
        check_true(t_reset, data_ok === 1'b0 && wr_req === 1'b0 && rd_req === 1'b0,
                   "data_ok, wr_req or rd_req is not low after reset");
        end_test(t_reset);

        prev_tag = tag_pool[0];
        prev_idx = idx_pool[0];
        for (int k = 0; k < n_req && !abort; k++) begin
                same = (k > 0) && ($urandom % 3 == 0);  // line just filled, must hit
                tag  = same ? prev_tag : tag_pool[$urandom % 3];
                idx  = same ? prev_idx : idx_pool[$urandom % 4];
                word = $urandom % 4;
                run_request(t_traffic, $urandom % 2, {tag, idx, word, 2'b00}, $urandom % 16,
                            $urandom, same, lat);
                prev_tag = tag;
                prev_idx = idx;
        end
        end_test(t_traffic);

        // fill every set with clean lines so all dirty ones get written back
        for (int s = 0; s < 4 && !abort; s++) begin
                settled = 1'b0;
                for (int tr = 0; tr < sweep_tries && !settled && !abort; tr++) begin
                        run_request(t_sweep, 1'b0, {sweep_tag[0], idx_pool[s], 4'h0}, 4'h0, 0,
                                    1'b0, lat);
                        run_request(t_sweep, 1'b0, {sweep_tag[1], idx_pool[s], 4'h4}, 4'h0, 0,
                                    1'b0, lat2);
                        settled = (lat == 1) && (lat2 == 1);
                end
                check_true(t_sweep, settled, "sweep could not evict the stored lines of a set");
        end
        for (int t = 0; t < 3; t++) begin
                for (int s = 0; s < 4; s++) begin
                        for (int w = 0; w < 4; w++) begin
                                baddr = {tag_pool[t], idx_pool[s], 4'h0} + 4 * w;
                                check_equal(t_sweep, ref_mem[baddr[15:2]],
                                            bridge.mem[baddr[15:2]]);
                        end
                end
        end
        end_test(t_sweep);
        end_test(t_wb);

        @(posedge clk);
        check_true(t_hs, pending == 0 && accepted == acked,
                   "accepted requests and data_ok pulses do not match");
        end_test(t_hs);

        total_err = 0;
        total_chk = 0;
        for (int i = 0; i < n_tests; i++) begin
                total_err += err_cnt[i];
                total_chk += chk_cnt[i];
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, total_chk, total_err);
        if (total_err == 0 && !abort)
                $display("Simulation passed");
        else
                $display("Simulation failed");
        $finish;
end

endmodule

// File: tb/cache_bridge_model.sv
`timescale 1ns/100ps

module cache_bridge_model (
        input   logic           clk,
        input   logic           resetn,
        input   logic           rd_req,
        input   logic [31:0]    rd_addr,
        output  logic           rd_rdy,
        output  logic           ret_valid,
        output  logic           ret_last,
        output  logic [31:0]    ret_data,
        input   logic           wr_req,
        input   logic [31:0]    wr_addr,
        input   logic [127:0]   wr_data,
        output  logic           wr_rdy
);

logic [31:0] mem [0:16383];     // word address bits 15:2
logic [11:0] rd_line;
logic [1:0]  beat;
logic        rd_busy;

function automatic logic [31:0] mem_init_word(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'h5ac30f0f;
endfunction

initial begin
        for (int a = 0; a < 16384; a++)
                mem[a] = mem_init_word(a);
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        rd_line   = '0;
        beat      = '0;
        rd_busy   = 1'b0;
end

always @(posedge clk) begin
        if (!resetn) begin
                rd_busy = 1'b0;
                beat    = '0;
        end else begin
                if (wr_req && wr_rdy) begin
                        for (int i = 0; i < 4; i++)
                                mem[{wr_addr[15:4], 2'b00} + i] = wr_data[32*i +: 32];
                end
                if (ret_valid) begin
                        beat = beat + 1'b1;
                        if (ret_last)
                                rd_busy = 1'b0;
                end
                if (rd_req && rd_rdy) begin
                        rd_busy = 1'b1;         // beats start next cycle
                        rd_line = rd_addr[15:4];
                        beat    = '0;
                end
        end
        #2;
        rd_rdy    = resetn && !rd_busy && ($urandom % 3 == 0);
        wr_rdy    = resetn && ($urandom % 3 == 0);
        ret_valid = rd_busy && ($urandom % 4 != 0);     // gaps between beats
        ret_last  = ret_valid && (beat == 2'd3);
        ret_data  = mem[{rd_line, beat}];
end

endmodule

// File: design/cache_top.sv
`timescale 1ns/100ps

module cache_top import cache_pkg::*; (
        input   logic           clk,
        input   logic           resetn,
        input   logic           valid,
        input   cpu_req_s       req,
        output  logic           addr_ok,
        output  logic           data_ok,
        output  logic [31:0]    rdata,
        output  logic           rd_req,
        output  logic [2:0]     rd_type,
        output  logic [31:0]    rd_addr,
        input   logic           rd_rdy,
        input   logic           ret_valid,
        input   logic           ret_last,
        input   logic [31:0]    ret_data,
        output  logic           wr_req,
        output  logic [2:0]     wr_type,
        output  logic [31:0]    wr_addr,
        output  logic [3:0]     wr_wstrb,
        output  logic [127:0]   wr_data,
        input   logic           wr_rdy
);

logic [index_w-1:0]             tag_rd_index;
logic [way_num-1:0][tag_w-1:0]  way_tag;
logic [way_num-1:0]             way_valid;
logic [way_num-1:0]             way_dirty;
line_t [way_num-1:0]            way_line;
logic [way_num-1:0]             hit_we;
logic [bank_w-1:0]              hit_bank;
logic [3:0]                     hit_strb;
logic [31:0]                    hit_data;
logic                           dirty_set;
logic                           miss_valid;
miss_req_s                      miss_req;
logic                           held_valid;
miss_req_s                      held_req;
logic [way_num-1:0]             fill_we;
logic [tag_w-1:0]               fill_tag;
logic                           fill_dirty;
word_wr_s                       data_wr;
word_wr_s                       hit_wr;
word_wr_s                       arr_wr;
logic                           refill_word_valid;
logic [31:0]                    refill_word;
logic                           refill_done;

assign rd_type  = rd_type_line;
assign wr_type  = wr_type_line;
assign wr_wstrb = 4'b1111;

assign hit_wr.way   = hit_we[1];
assign hit_wr.index = tag_rd_index;
assign hit_wr.bank  = hit_bank;
assign hit_wr.strb  = hit_strb & {4{|hit_we}};
assign hit_wr.data  = hit_data;
assign arr_wr       = (|data_wr.strb) ? data_wr : hit_wr;   // refill first

cache_lookup u_lookup (
        .clk(clk), .resetn(resetn),
        .valid(valid), .req(req), .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .tag_rd_index(tag_rd_index),
        .way_tag(way_tag), .way_valid(way_valid), .way_dirty(way_dirty), .way_line(way_line),
        .hit_we(hit_we), .hit_bank(hit_bank), .hit_strb(hit_strb), .hit_data(hit_data),
        .dirty_set(dirty_set), .miss_valid(miss_valid), .miss_req(miss_req),
        .refill_done(refill_done), .refill_word_valid(refill_word_valid),
        .refill_word(refill_word)
);

cache_tag_array u_tag_array (
        .clk(clk), .resetn(resetn), .rd_index(tag_rd_index),
        .way_tag(way_tag), .way_valid(way_valid), .way_dirty(way_dirty),
        .fill_we(fill_we), .fill_index(held_req.req.addr.f.index),
        .fill_tag(fill_tag), .fill_dirty(fill_dirty),
        .dirty_set(dirty_set), .dirty_way(hit_we[1]), .dirty_index(tag_rd_index)
);

cache_data_array u_data_array (
        .clk(clk), .rd_index(tag_rd_index), .way_line(way_line),
        .wr_way(arr_wr.way), .wr_index(arr_wr.index), .wr_bank(arr_wr.bank),
        .wr_strb(arr_wr.strb), .wr_data(arr_wr.data)
);

cache_victim_buffer u_victim_buffer (
        .clk(clk), .resetn(resetn), .miss_valid(miss_valid), .miss_req(miss_req),
        .refill_done(refill_done), .held_valid(held_valid), .held_req(held_req)
);

cache_refill_engine u_refill_engine (
        .clk(clk), .resetn(resetn), .held_valid(held_valid), .held_req(held_req),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .fill_we(fill_we), .fill_tag(fill_tag), .fill_dirty(fill_dirty),
        .data_wr(data_wr), .refill_word_valid(refill_word_valid),
        .refill_word(refill_word), .refill_done(refill_done)
);

endmodule

// File: design/cache_refill_engine.sv
`timescale 1ns/100ps

module cache_refill_engine import cache_pkg::*; (
        input   logic                   clk,
        input   logic                   resetn,
        input   logic                   held_valid,
        input   miss_req_s              held_req,
        output  logic                   wr_req,
        output  logic [31:0]            wr_addr,
        output  line_t                  wr_data,
        input   logic                   wr_rdy,
        output  logic                   rd_req,
        output  logic [31:0]            rd_addr,
        input   logic                   rd_rdy,
        input   logic                   ret_valid,
        input   logic                   ret_last,
        input   logic [31:0]            ret_data,
        output  logic [way_num-1:0]     fill_we,
        output  logic [tag_w-1:0]       fill_tag,
        output  logic                   fill_dirty,
        output  word_wr_s               data_wr,
        output  logic                   refill_word_valid,
        output  logic [31:0]            refill_word,
        output  logic                   refill_done
);

typedef enum logic [1:0] {st_idle, st_wb, st_rd, st_refill} state_e;

state_e            state;
state_e            state_nxt;
logic [bank_w-1:0] beat;
logic [bank_w-1:0] req_bank;
logic              beat_take;
logic [31:0]       fill_word;
cache_addr_u       wb_addr;
cache_addr_u       line_addr;

assign req_bank  = held_req.req.addr.f.offset[offset_w-1:2];
assign beat_take = (state == st_refill) && ret_valid;

always_ff @(posedge clk) begin
        if (!resetn)
                state <= st_idle;
        else
                state <= state_nxt;
end

always_comb begin
        state_nxt = state;
        case (state)
                st_idle: begin
                        if (held_valid)
                                state_nxt = held_req.victim_dirty ? st_wb : st_rd;
                end
                st_wb: begin
                        if (wr_rdy)
                                state_nxt = st_rd;
                end
                st_rd: begin
                        if (rd_rdy)
                                state_nxt = st_refill;
                end
                st_refill: begin
                        if (ret_valid && ret_last)
                                state_nxt = st_idle;
                end
                default: state_nxt = st_idle;
        endcase
end

always_ff @(posedge clk) begin
        if (!resetn)
                beat <= '0;
        else if (beat_take)
                beat <= ret_last ? '0 : beat + 1'b1;
end

always_comb begin
        wb_addr.f.tag      = held_req.victim_tag;
        wb_addr.f.index    = held_req.req.addr.f.index;
        wb_addr.f.offset   = '0;
        line_addr          = held_req.req.addr;
        line_addr.f.offset = '0;        // line aligned
end

// pending store bytes go over the returned word
always_comb begin
        fill_word = ret_data;
        if (held_req.req.op && beat == req_bank) begin
                for (int i = 0; i < 4; i++) begin
                        if (held_req.req.wstrb[i])
                                fill_word[8*i +: 8] = held_req.req.wdata[8*i +: 8];
                end
        end
end

assign wr_req  = (state == st_wb);
assign wr_addr = wb_addr.raw;
assign wr_data = held_req.victim_line;
assign rd_req  = (state == st_rd);
assign rd_addr = line_addr.raw;

assign data_wr.way   = held_req.way;
assign data_wr.index = held_req.req.addr.f.index;
assign data_wr.bank  = beat;
assign data_wr.strb  = {4{beat_take}};
assign data_wr.data  = fill_word;

assign refill_word_valid = beat_take && (beat == req_bank);
assign refill_word       = fill_word;
assign refill_done       = beat_take && ret_last;

always_comb begin
        for (int w = 0; w < way_num; w++) begin
                fill_we[w] = refill_done && (held_req.way == way_w'(w)); // tag on last beat
        end
end

assign fill_tag   = held_req.req.addr.f.tag;
assign fill_dirty = held_req.req.op;

ret_only_in_refill: assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> state == st_refill);

endmodule

// File: design/cache_victim_buffer.sv
`timescale 1ns/100ps

module cache_victim_buffer import cache_pkg::*; (
        input   logic           clk,
        input   logic           resetn,
        input   logic           miss_valid,
        input   miss_req_s      miss_req,
        input   logic           refill_done,
        output  logic           held_valid,
        output  miss_req_s      held_req
);

// full from the cycle after the miss pulse until the refill ends
always_ff @(posedge clk) begin
        if (!resetn)
                held_valid <= 1'b0;
        else if (miss_valid)
                held_valid <= 1'b1;
        else if (refill_done)
                held_valid <= 1'b0;
end

// victim line stays put while the arrays are overwritten
always_ff @(posedge clk) begin
        if (miss_valid)
                held_req <= miss_req;
end

no_miss_when_full: assert property (@(posedge clk) disable iff (!resetn)
        miss_valid |-> !held_valid);

endmodule

// File: design/cache_lookup.sv
`timescale 1ns/100ps

module cache_lookup import cache_pkg::*; (
        input   logic                           clk,
        input   logic                           resetn,
        input   logic                           valid,
        input   cpu_req_s                       req,
        output  logic                           addr_ok,
        output  logic                           data_ok,
        output  logic [31:0]                    rdata,
        output  logic [index_w-1:0]             tag_rd_index,
        input   logic [way_num-1:0][tag_w-1:0]  way_tag,
        input   logic [way_num-1:0]             way_valid,
        input   logic [way_num-1:0]             way_dirty,
        input   line_t [way_num-1:0]            way_line,
        output  logic [way_num-1:0]             hit_we,
        output  logic [bank_w-1:0]              hit_bank,
        output  logic [3:0]                     hit_strb,
        output  logic [31:0]                    hit_data,
        output  logic                           dirty_set,
        output  logic                           miss_valid,
        output  miss_req_s                      miss_req,
        input   logic                           refill_done,
        input   logic                           refill_word_valid,
        input   logic [31:0]                    refill_word
);

typedef enum logic [1:0] {st_idle, st_lookup, st_blocked} state_e;

state_e             state;
state_e             state_nxt;
cpu_req_s           req_q;
logic [way_num-1:0] way_hit;
logic               hit;
logic [bank_w-1:0]  bank;
logic [31:0]        hit_word;
logic [7:0]         lfsr;
logic [way_w-1:0]   victim;

always_ff @(posedge clk) begin
        if (!resetn)
                state <= st_idle;
        else
                state <= state_nxt;
end

always_comb begin
        state_nxt = state;
        case (state)
                st_idle: begin
                        if (valid)
                                state_nxt = st_lookup;
                end
                st_lookup: begin
                        state_nxt = hit ? st_idle : st_blocked;
                end
                st_blocked: begin
                        if (refill_done)
                                state_nxt = st_idle;
                end
                default: state_nxt = st_idle;
        endcase
end

always_ff @(posedge clk) begin
        if (state == st_idle && valid)
                req_q <= req;
end

// free running, x^8 + x^6 + x^5 + x^4 + 1
always_ff @(posedge clk) begin
        if (!resetn)
                lfsr <= 8'h01;
        else
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
end

assign bank = req_q.addr.f.offset[offset_w-1:2];

always_comb begin
        hit_word = '0;
        for (int w = 0; w < way_num; w++) begin
                way_hit[w] = way_valid[w] && (way_tag[w] == req_q.addr.f.tag);
                if (way_hit[w])
                        hit_word = way_line[w][bank];
        end
end

assign hit = |way_hit;

// an empty way wins over the random pick
always_comb begin
        victim = lfsr[way_w-1:0];
        for (int w = way_num - 1; w >= 0; w--) begin
                if (!way_valid[w])
                        victim = way_w'(w);
        end
end

assign addr_ok = (state == st_idle);
assign data_ok = (state == st_lookup && (hit || req_q.op)) ||
                 (state == st_blocked && refill_word_valid && !req_q.op);
assign rdata   = (state == st_blocked) ? refill_word : hit_word;

// held index doubles as the store hit write index
assign tag_rd_index = (state == st_idle) ? req.addr.f.index : req_q.addr.f.index;

assign hit_we    = way_hit & {way_num{state == st_lookup && req_q.op}};
assign hit_bank  = bank;
assign hit_strb  = req_q.wstrb;
assign hit_data  = req_q.wdata;
assign dirty_set = |hit_we;

assign miss_valid            = (state == st_lookup) && !hit;
assign miss_req.req          = req_q;
assign miss_req.way          = victim;
assign miss_req.victim_tag   = way_tag[victim];
assign miss_req.victim_dirty = way_valid[victim] && way_dirty[victim];
assign miss_req.victim_line  = way_line[victim];

// refill results only come back for the miss being waited on
refill_only_when_blocked: assert property (@(posedge clk) disable iff (!resetn)
        (refill_done || refill_word_valid) |-> state == st_blocked);

endmodule

// File: design/cache_data_array.sv
`timescale 1ns/100ps

module cache_data_array import cache_pkg::*; (
        input   logic                   clk,
        input   logic [index_w-1:0]     rd_index,
        output  line_t [way_num-1:0]    way_line,
        input   logic [way_w-1:0]       wr_way,
        input   logic [index_w-1:0]     wr_index,
        input   logic [bank_w-1:0]      wr_bank,
        input   logic [3:0]             wr_strb,
        input   logic [31:0]            wr_data
);

// one word per way, bank and set
logic [31:0] mem [way_num][bank_num][set_num];

always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
                if (wr_strb[b])
                        mem[wr_way][wr_bank][wr_index][8*b +: 8] <= wr_data[8*b +: 8];
        end
end

// full line of every way, read old data on a collision
always_ff @(posedge clk) begin
        for (int w = 0; w < way_num; w++) begin
                for (int k = 0; k < bank_num; k++) begin
                        way_line[w][k] <= mem[w][k][rd_index];
                end
        end
end

endmodule

// File: design/cache_tag_array.sv
`timescale 1ns/100ps

module cache_tag_array import cache_pkg::*; (
        input   logic                           clk,
        input   logic                           resetn,
        input   logic [index_w-1:0]             rd_index,
        output  logic [way_num-1:0][tag_w-1:0]  way_tag,
        output  logic [way_num-1:0]             way_valid,
        output  logic [way_num-1:0]             way_dirty,
        input   logic [way_num-1:0]             fill_we,
        input   logic [index_w-1:0]             fill_index,
        input   logic [tag_w-1:0]               fill_tag,
        input   logic                           fill_dirty,
        input   logic                           dirty_set,
        input   logic [way_w-1:0]               dirty_way,
        input   logic [index_w-1:0]             dirty_index
);

logic [tag_w-1:0]                 tag_mem [way_num][set_num];
logic [way_num-1:0][set_num-1:0]  valid_bits;
logic [way_num-1:0][set_num-1:0]  dirty_bits;

always_ff @(posedge clk) begin
        if (!resetn) begin
                valid_bits <= '0;
                dirty_bits <= '0;
        end else begin
                for (int w = 0; w < way_num; w++) begin
                        if (fill_we[w]) begin
                                valid_bits[w][fill_index] <= 1'b1;
                                dirty_bits[w][fill_index] <= fill_dirty; // store miss refills dirty
                        end
                end
                if (dirty_set)
                        dirty_bits[dirty_way][dirty_index] <= 1'b1;
        end
end

// tags and the synchronous read port
always_ff @(posedge clk) begin
        for (int w = 0; w < way_num; w++) begin
                if (fill_we[w])
                        tag_mem[w][fill_index] <= fill_tag;
                way_tag[w]   <= tag_mem[w][rd_index];
                way_valid[w] <= valid_bits[w][rd_index];
                way_dirty[w] <= dirty_bits[w][rd_index];
        end
end

endmodule

// File: design/cache_pkg.sv
package cache_pkg;

localparam int way_num  = 2;
localparam int set_num  = 256;
localparam int bank_num = 4;
localparam int tag_w    = 20;
localparam int index_w  = 8;
localparam int offset_w = 4;
localparam int way_w    = $clog2(way_num);
localparam int bank_w   = $clog2(bank_num);

localparam logic [2:0] rd_type_line = 3'b100;
localparam logic [2:0] wr_type_line = 3'b100;

typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
} addr_fields_s;

// cpu side splits the address, bridge side sends it whole
typedef union packed {
        logic [31:0]  raw;
        addr_fields_s f;
} cache_addr_u;

typedef logic [bank_num-1:0][31:0] line_t;      // word 0 in the low bits

typedef struct packed {
        logic        op;        // 1: store
        cache_addr_u addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
} cpu_req_s;

typedef struct packed {
        cpu_req_s         req;
        logic [way_w-1:0] way;
        logic [tag_w-1:0] victim_tag;
        logic             victim_dirty;     // valid and dirty
        line_t            victim_line;
} miss_req_s;

typedef struct packed {
        logic [way_w-1:0]   way;
        logic [index_w-1:0] index;
        logic [bank_w-1:0]  bank;
        logic [3:0]         strb;       // zero strobe means no write
        logic [31:0]        data;
} word_wr_s;

endpackage
